// File: source/sigmoidPkg.sv
package sigmoidPkg;

	// Datapath widths
	localparam int SAMPLE_W   = 8;
	localparam int SLOPE_W    = 4;
	localparam int ICPT_W     = 10;
	localparam int PART_W     = 10;
	localparam int FUNC_W     = 12;
	localparam int Y_W        = 16;
	localparam int SEG_W      = 3;

	// Input strobe to output strobe, in clock cycles
	localparam int PIPE_DEPTH = 6;

	// Sample and magnitude
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic        [SAMPLE_W-1:0] mag_t;

	// Slope counts in units of 2^-6, intercept is a pure fraction
	typedef logic [SLOPE_W-1:0] slope_t;
	typedef logic [ICPT_W-1:0]  icpt_t;

	// Multiplier partials and results
	typedef logic [PART_W-1:0] part_t;
	typedef logic [FUNC_W-1:0] func_t;
	typedef logic [Y_W-1:0]    y_t;
	typedef logic [SEG_W-1:0]  segIdx_t;

	// Coefficients of one segment
	typedef struct packed {
		slope_t slope;
		icpt_t  icpt;
	} segCoef_t;

	// Pairs of gated magnitudes, the upper pair weighs four times the lower
	typedef struct packed {
		part_t sum01;
		part_t sum23;
	} mulPart_t;

	// Operands of the final add
	typedef struct packed {
		func_t product;
		icpt_t icpt;
	} termPair_t;

	// Segment coefficients, index is the segment number
	localparam slope_t SLOPE_TABLE [0:2**SEG_W-1] = '{
		4'd15, 4'd14, 4'd11, 4'd8,
		4'd6,  4'd4,  4'd2,  4'd1
	};

	localparam icpt_t ICPT_TABLE [0:2**SEG_W-1] = '{
		10'h003, 10'h01D, 10'h07E, 10'h10F,
		10'h18B, 10'h224, 10'h2E2, 10'h358
	};

endpackage

// File: source/sigmoidCtrl.sv
`timescale 1ns/10ps

module sigmoidCtrl (
	input  logic clk,
	input  logic i_rstN,
	input  logic i_inValid,
	input  logic i_sign,
	output logic o_sign,
	output logic o_outValid
);
	import sigmoidPkg::*;

	// Sign arrives one stage late from the fold and is consumed one stage
	// before the output register
	localparam int SIGN_DEPTH = PIPE_DEPTH - 2;

	logic [PIPE_DEPTH-1:0] validPipe;
	logic [SIGN_DEPTH-1:0] signPipe;

	// Valid strobe rides beside the sample through every stage
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[PIPE_DEPTH-2:0], i_inValid};
		end
	end

	// Sign from stage 1 up to stage 5
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			signPipe <= '0;
		end else begin
			signPipe <= {signPipe[SIGN_DEPTH-2:0], i_sign};
		end
	end

	assign o_outValid = validPipe[PIPE_DEPTH-1];
	assign o_sign     = signPipe[SIGN_DEPTH-1];

endmodule

// File: source/inputFold.sv
`timescale 1ns/10ps

module inputFold (
	input  logic                clk,
	input  logic                i_rstN,
	input  sigmoidPkg::sample_t i_x,
	output sigmoidPkg::mag_t    o_mag,
	output logic                o_sign
);
	import sigmoidPkg::*;

	logic xSign;
	mag_t absX;

	assign xSign = i_x[SAMPLE_W-1];

	// Two's complement negate for negative samples
	// -128 folds to 128, which still fits the unsigned magnitude
	always_comb begin
		if (xSign) begin
			absX = mag_t'(~i_x + 1'b1);
		end else begin
			absX = mag_t'(i_x);
		end
	end

	// Stage 1 register
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_mag  <= '0;
			o_sign <= 1'b0;
		end else begin
			o_mag  <= absX;
			o_sign <= xSign;
		end
	end

endmodule

// File: source/segmentLookup.sv
`timescale 1ns/10ps

module segmentLookup (
	input  logic                 clk,
	input  logic                 i_rstN,
	input  sigmoidPkg::mag_t     i_mag,
	output sigmoidPkg::mag_t     o_mag,
	output sigmoidPkg::segCoef_t o_coef
);
	import sigmoidPkg::*;

	// Segments are 16 wide, so the index is the bits just below the MSB
	localparam int IDX_MSB = SAMPLE_W - 2;

	segIdx_t  segIdx;
	segCoef_t coef;

	// Magnitude 128 only happens for x = -128, it uses the last segment
	always_comb begin
		if (i_mag[SAMPLE_W-1]) begin
			segIdx = '1;
		end else begin
			segIdx = i_mag[IDX_MSB -: SEG_W];
		end
	end

	// Table read
	always_comb begin
		coef.slope = SLOPE_TABLE[segIdx];
		coef.icpt  = ICPT_TABLE[segIdx];
	end

	// Stage 2 register, magnitude travels on for the multiply
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_mag  <= '0;
			o_coef <= '0;
		end else begin
			o_mag  <= i_mag;
			o_coef <= coef;
		end
	end

endmodule

// File: source/slopeMultiply.sv
`timescale 1ns/10ps

module slopeMultiply (
	input  logic                  clk,
	input  logic                  i_rstN,
	input  sigmoidPkg::mag_t      i_mag,
	input  sigmoidPkg::segCoef_t  i_coef,
	output sigmoidPkg::termPair_t o_terms
);
	import sigmoidPkg::*;

	mag_t     gated [SLOPE_W];
	mulPart_t partNext;
	mulPart_t partReg;
	icpt_t    icptReg;
	func_t    product;

	// One copy of the magnitude per slope bit
	always_comb begin
		for (int k = 0; k < SLOPE_W; k++) begin
			gated[k] = i_coef.slope[k] ? i_mag : '0;
		end
	end

	// First adder level, bits 0+1 and bits 2+3
	always_comb begin
		partNext.sum01 = part_t'(gated[0]) + (part_t'(gated[1]) << 1);
		partNext.sum23 = part_t'(gated[2]) + (part_t'(gated[3]) << 1);
	end

	// Stage 3 register
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			partReg <= '0;
			icptReg <= '0;
		end else begin
			partReg <= partNext;
			icptReg <= i_coef.icpt;
		end
	end

	// Second adder level, upper pair sits two bits higher
	assign product = func_t'(partReg.sum01) + (func_t'(partReg.sum23) << 2);

	// Stage 4 register
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_terms <= '0;
		end else begin
			o_terms.product <= product;
			o_terms.icpt    <= icptReg;
		end
	end

endmodule

// File: source/outputFormat.sv
`timescale 1ns/10ps

module outputFormat (
	input  logic                  clk,
	input  logic                  i_rstN,
	input  sigmoidPkg::termPair_t i_terms,
	input  logic                  i_sign,
	output sigmoidPkg::y_t        o_y
);
	import sigmoidPkg::*;

	// Bits of the function result that reach the output word
	localparam int         MIRROR_W = FUNC_W - 1;
	localparam logic [2:0] Y_TAIL   = 3'b011;

	func_t                funcSum;
	func_t                funcReg;
	logic [MIRROR_W-1:0]  mirrored;
	y_t                   yNext;

	// Intercept carries an implicit 1.0 above its fraction
	assign funcSum = i_terms.product + func_t'({1'b1, i_terms.icpt});

	// Stage 5 register
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			funcReg <= '0;
		end else begin
			funcReg <= funcSum;
		end
	end

	// Negative inputs give 1 - f, done as a bit inversion
	assign mirrored = funcReg[MIRROR_W-1:0] ^ {MIRROR_W{i_sign}};

	// Word layout: zero, result, sign, fixed tail
	assign yNext = {1'b0, mirrored, i_sign, Y_TAIL};

	// Output register
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_y <= '0;
		end else begin
			o_y <= yNext;
		end
	end

endmodule

// File: source/sigmoid.sv
`timescale 1ns/10ps

module sigmoid (
	input  logic               clk,
	input  logic               i_rstN,
	input  logic               i_inValid,
	input  sigmoidPkg::sample_t i_x,
	output sigmoidPkg::y_t     o_y,
	output logic               o_outValid
);
	import sigmoidPkg::*;

	// Stage 1 outputs of the fold
	mag_t      foldMag;
	logic      foldSign;

	// Stage 2 outputs of the table lookup
	mag_t      lookMag;
	segCoef_t  lookCoef;

	// Stage 4 operands for the final add
	termPair_t mulTerms;

	// Sign lined up with the mirror stage
	logic      alignSign;

	// Valid and sign delay line
	sigmoidCtrl sigmoidCtrl_inst (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.i_inValid  (i_inValid),
		.i_sign     (foldSign),
		.o_sign     (alignSign),
		.o_outValid (o_outValid)
	);

	// Stage 0 to 1
	inputFold inputFold_inst (
		.clk    (clk),
		.i_rstN (i_rstN),
		.i_x    (i_x),
		.o_mag  (foldMag),
		.o_sign (foldSign)
	);

	// Stage 1 to 2
	segmentLookup segmentLookup_inst (
		.clk    (clk),
		.i_rstN (i_rstN),
		.i_mag  (foldMag),
		.o_mag  (lookMag),
		.o_coef (lookCoef)
	);

	// Stage 2 to 4
	slopeMultiply slopeMultiply_inst (
		.clk     (clk),
		.i_rstN  (i_rstN),
		.i_mag   (lookMag),
		.i_coef  (lookCoef),
		.o_terms (mulTerms)
	);

	// Stage 4 to 6
	outputFormat outputFormat_inst (
		.clk     (clk),
		.i_rstN  (i_rstN),
		.i_terms (mulTerms),
		.i_sign  (alignSign),
		.o_y     (o_y)
	);

endmodule

// File: test/sigmoid_chk.sv
`timescale 1ns/10ps

module sigmoid_chk (
	input logic               clk,
	input logic               i_rstN,
	input logic               i_inValid,
	input sigmoidPkg::y_t     o_y,
	input logic               o_outValid
);
	import sigmoidPkg::*;

	// Number of failed assertions so far
	int unsigned failCount = 0;

	// Strobe is cleared by reset and needs a full pipeline to refill
	validLowAfterReset: assert property (@(posedge clk)
		!i_rstN |=> !o_outValid [*PIPE_DEPTH])
	else begin
		failCount++;
		$error("o_outValid high within %0d cycles of reset", PIPE_DEPTH);
	end

	// Output strobe repeats the input strobe once no reset interrupts the pipe
	validFollowsInput: assert property (@(posedge clk)
		i_rstN [*PIPE_DEPTH] |=> (o_outValid == $past(i_inValid, PIPE_DEPTH)))
	else begin
		failCount++;
		$error("o_outValid does not match i_inValid from %0d cycles earlier", PIPE_DEPTH);
	end

	// Fixed bits of the output word
	fixedBitsOnValid: assert property (@(posedge clk)
		o_outValid |-> (o_y[2:0] == 3'b011 && !o_y[Y_W-1]))
	else begin
		failCount++;
		$error("o_y fixed bits wrong, o_y = 0x%04h", o_y);
	end

endmodule

bind sigmoid sigmoid_chk sigmoidChk_inst (.*);

// File: test/sigmoidTb.sv
`timescale 1ns/10ps

module sigmoidTb;
	import sigmoidPkg::*;

	localparam int RESET_CYCLES   = 10;
	localparam int STREAM_COUNT   = 200;
	localparam int GAP_COUNT      = 200;
	localparam int DIRECTED_COUNT = 8 + 7 + 3;
	localparam int MARGIN         = 50;

	// Each directed sample waits for its own result and each stream drains once
	localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_COUNT * (PIPE_DEPTH + 1)
		+ STREAM_COUNT + GAP_COUNT + 3 * PIPE_DEPTH + MARGIN;

	// Segment coefficients of the curve
	localparam int SLOPE_REF [0:7] = '{15, 14, 11, 8, 6, 4, 2, 1};
	localparam int ICPT_REF  [0:7] = '{'h003, 'h01D, 'h07E, 'h10F, 'h18B, 'h224, 'h2E2, 'h358};

	// x = 0 plus one sample inside each of segments 0 to 6
	localparam int POS_SAMPLES [0:7] = '{0, 5, 23, 40, 57, 70, 90, 105};
	localparam int EXT_SAMPLES [0:2] = '{127, -127, -128};

	logic        clk;
	logic        rstN;
	logic        inValid;
	sample_t     sample;
	y_t          yOut;
	logic        outValid;

	logic [31:0] lcgState;
	int          cycleCount = 0;

	// Expected results of valid samples and every driven strobe
	y_t          expQ[$];
	logic        validHist[$];

	sigmoid sigmoid_inst (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_x        (sample),
		.o_y        (yOut),
		.o_outValid (outValid)
	);

	always #5 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout, tests still running after %0d cycles", cycleCount);
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// Stop at the first failed assertion of the bound checker
	always @(posedge clk) begin
		if (sigmoid_inst.sigmoidChk_inst.failCount != 0) begin
			$display("Bound checker reported a failed assertion");
			$display("Test failed");
			$fatal(1, "assertion failure");
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Sigmoid approximation worked out from the segment rule
	function automatic y_t modelY(input sample_t xs);
		int          mag;
		int          seg;
		logic        neg;
		logic [11:0] f;
		logic [10:0] g;
		neg = (xs < 0);
		mag = neg ? -int'(xs) : int'(xs);
		if (mag >= 128) begin
			seg = 7;
		end else begin
			seg = mag / 16;
		end
		f = 12'(mag * SLOPE_REF[seg] + 1024 + ICPT_REF[seg]);
		g = neg ? ~f[10:0] : f[10:0];
		return {1'b0, g, neg, 3'b011};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("error: %s is 0x%04h, expected 0x%04h", name, actual, expected);
			$display("Test failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// One clock that checks what came out and then drives the next input
	task automatic driveCycle(input logic valid, input sample_t xs);
		logic expValid;
		y_t   expY;
		@(negedge clk);
		if (validHist.size() == PIPE_DEPTH) begin
			expValid = validHist.pop_front();
		end else begin
			expValid = 1'b0;
		end
		checkValue("o_outValid", 16'(outValid), 16'(expValid));
		if (outValid) begin
			expY = expQ.pop_front();
			checkValue("o_y", yOut, expY);
		end
		inValid = valid;
		sample  = xs;
		validHist.push_back(valid);
		if (valid) begin
			expQ.push_back(modelY(xs));
		end
	endtask

	// Idle until every outstanding result has come out
	task automatic drainPipe(output int cycles);
		cycles = 0;
		while (expQ.size() != 0) begin
			driveCycle(1'b0, '0);
			cycles++;
		end
	endtask

	task automatic checkOneSample(input sample_t xs);
		int latency;
		driveCycle(1'b1, xs);
		drainPipe(latency);
		checkValue("o_outValid latency", 16'(latency), 16'(PIPE_DEPTH));
	endtask

	task automatic resetTest();
		rstN = 1'b0;
		repeat (RESET_CYCLES) driveCycle(1'b0, '0);
		rstN = 1'b1;
	endtask

	task automatic positiveTest();
		for (int i = 0; i < 8; i++) begin
			checkOneSample(sample_t'(POS_SAMPLES[i]));
		end
	endtask

	// Mirrored points of the positive test without zero
	task automatic negativeTest();
		for (int i = 1; i < 8; i++) begin
			checkOneSample(sample_t'(-POS_SAMPLES[i]));
		end
	endtask

	task automatic extremeTest();
		for (int i = 0; i < 3; i++) begin
			checkOneSample(sample_t'(EXT_SAMPLES[i]));
		end
	endtask

	// Back to back samples keep six in flight
	task automatic streamTest();
		int n;
		for (int i = 0; i < STREAM_COUNT; i++) begin
			lcgState = lcgNext(lcgState);
			driveCycle(1'b1, sample_t'(lcgState[23:16]));
		end
		drainPipe(n);
	endtask

	task automatic gapTest();
		int n;
		for (int i = 0; i < GAP_COUNT; i++) begin
			lcgState = lcgNext(lcgState);
			driveCycle(lcgState[27], sample_t'(lcgState[19:12]));
		end
		drainPipe(n);
	endtask

	initial begin
		clk      = 1'b0;
		rstN     = 1'b0;
		inValid  = 1'b0;
		sample   = '0;
		lcgState = 32'h6154_acf9;

		resetTest();
		positiveTest();
		negativeTest();
		extremeTest();
		streamTest();
		gapTest();

		// Let the last strobes of the gap pattern reach the output
		repeat (PIPE_DEPTH) driveCycle(1'b0, '0);

		if (sigmoid_inst.sigmoidChk_inst.failCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Bound checker saw %0d assertion failures",
				sigmoid_inst.sigmoidChk_inst.failCount);
			$display("Test failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: sigmoid.f
source/sigmoidPkg.sv
source/sigmoidCtrl.sv
source/inputFold.sv
source/segmentLookup.sv
source/slopeMultiply.sv
source/outputFormat.sv
source/sigmoid.sv
test/sigmoid_chk.sv
test/sigmoidTb.sv
